// File: include/scaler_config.svh
// widths and fixed-point constants of the horizontal scaler
// include wherever a width or the coordinate unit is needed
`ifndef SCALER_CONFIG_SVH
`define SCALER_CONFIG_SVH

// pixel stream
`define SCALER_DATA_W   8       // one component per pixel

// filter coefficients, magnitude only
`define SCALER_COE_W    10      // 1.0 = 512

// coordinate counters
`define SCALER_PIX_STEP 4096    // one input pixel in 4.12 units

// coefficient table
`define SCALER_PHASES   32
`define SCALER_PHASE_W  5       // log2 of the phase count

`endif

// File: source/scaler_pkg.sv
// shared types of the horizontal scaler
// the step word is read both as an adder value and as int/phase fields
`include "scaler_config.svh"

package scaler_pkg;

    // ----------------------------------------
    // scale step, 4.12 unsigned fixed point
    // ----------------------------------------

    typedef struct packed {
        logic [3:0]  int_part;  // whole input pixels per output
        logic [11:0] frac;      // top bits select the filter phase
    } step_fields_t;

    // same 16 bits, two readings
    typedef union packed {
        logic [15:0]  raw;      // added straight onto the output counter
        step_fields_t f;
    } scale_step_t;

    // ----------------------------------------
    // stream and filter words
    // ----------------------------------------

    typedef logic [`SCALER_DATA_W-1:0] pixel_t;

    // tap magnitude, the sign is fixed by tap position
    typedef logic [`SCALER_COE_W-1:0] coe_t;

endpackage

// File: source/scaler_coe_rom.sv
// cubic interpolation coefficients, one row of four taps per phase
// taps 0 and 3 are negative lobes, taps 1 and 2 positive
// output registered so the table maps onto block ROM
`timescale 1ns/1ps

`include "scaler_config.svh"

module scaler_coe_rom (
    input  logic                       clk,
    input  logic [`SCALER_PHASE_W-1:0] phase_i,
    output scaler_pkg::coe_t           coe0_o,    // oldest tap, subtracted
    output scaler_pkg::coe_t           coe1_o,
    output scaler_pkg::coe_t           coe2_o,
    output scaler_pkg::coe_t           coe3_o     // newest tap, subtracted
);

    // ----------------------------------------
    // catmull-rom weights at t = phase/32
    // ----------------------------------------
    // tap0 = t(1-t)^2/2, tap3 = t^2(1-t)/2, tap2 = (-3t^3+4t^2+t)/2
    // tap1 is derived from the others so every row nets exactly 512
    // rows above 16 mirror the rows below it

    localparam scaler_pkg::coe_t COE_TAB [`SCALER_PHASES][4] = '{
        '{  0, 512,   0,   0},  // t = 0 copies tap 1
        '{  8, 511,   9,   0},
        '{ 14, 507,  20,   1},
        '{ 20, 502,  32,   2},
        '{ 25, 494,  47,   4},  // 1/8
        '{ 28, 483,  62,   5},
        '{ 32, 472,  79,   7},
        '{ 34, 459,  97,  10},
        '{ 36, 444, 116,  12},  // quarter pixel
        '{ 37, 428, 136,  15},
        '{ 38, 410, 157,  17},
        '{ 38, 392, 178,  20},
        '{ 38, 373, 200,  23},
        '{ 37, 352, 222,  25},
        '{ 35, 331, 244,  28},
        '{ 34, 310, 266,  30},
        '{ 32, 288, 288,  32},  // half pixel, symmetric
        '{ 30, 266, 310,  34},
        '{ 28, 244, 331,  35},
        '{ 25, 222, 352,  37},
        '{ 23, 200, 373,  38},
        '{ 20, 178, 392,  38},
        '{ 17, 157, 410,  38},
        '{ 15, 136, 428,  37},
        '{ 12, 116, 444,  36},  // three quarters
        '{ 10,  97, 459,  34},
        '{  7,  79, 472,  32},
        '{  5,  62, 483,  28},
        '{  4,  47, 494,  25},
        '{  2,  32, 502,  20},
        '{  1,  20, 507,  14},
        '{  0,   9, 511,   8}
    };

    // ----------------------------------------
    // registered read
    // ----------------------------------------

    // one clock of latency, lines up with the captured taps
    always_ff @(posedge clk) begin
        coe0_o <= COE_TAB[phase_i][0];
        coe1_o <= COE_TAB[phase_i][1];
        coe2_o <= COE_TAB[phase_i][2];
        coe3_o <= COE_TAB[phase_i][3];
    end

endmodule

// File: source/scaler_h.sv
// horizontal resampler with a four-tap cubic filter
// input coordinate grows one unit per accepted pixel, output by scale_step_i
// a pixel is issued whenever the input coordinate passes the output one
// latency from issue to de_o and from qualified sync to hs_o/vs_o is 3 clocks
`timescale 1ns/1ps

`include "scaler_config.svh"

module scaler_h (
    input  logic                    clk,
    input  logic                    rst,
    input  scaler_pkg::scale_step_t scale_step_i,   // 4.12, 4096 = 1.0
    input  scaler_pkg::pixel_t      pix_i,
    input  logic                    de_i,
    input  logic                    hs_i,
    input  logic                    vs_i,
    output scaler_pkg::pixel_t      pix_o,
    output logic                    de_o,
    output logic                    hs_o,
    output logic                    vs_o
);

    localparam int CNT_W      = 24;
    localparam int POS_FRAC_W = $clog2(`SCALER_PIX_STEP);    // 12 fraction bits
    localparam int SYNC_HOLD  = 4;                           // clocks before a sync counts
    localparam int FRAC_W     = `SCALER_COE_W - 1;           // 1.0 = 512
    localparam int MUL_W      = `SCALER_COE_W + `SCALER_DATA_W;
    localparam int SUM_W      = MUL_W + 2;                   // sign and overshoot
    localparam int OVF_BIT    = FRAC_W + `SCALER_DATA_W;

    localparam logic [CNT_W-1:0] ONE_PIX    = CNT_W'(`SCALER_PIX_STEP);
    localparam logic [CNT_W-1:0] GRP_DELAY  = CNT_W'(3 * `SCALER_PIX_STEP);
    localparam logic [SUM_W-1:0] ROUND_HALF = SUM_W'(1) << (FRAC_W - 1);

    // sync qualification
    logic [1:0]                sync_in;     // {vs, hs}
    logic [1:0][SYNC_HOLD-1:0] sync_sr;
    logic [1:0]                sync_q;
    logic                      sync_any;

    // coordinates
    logic                       accept;
    logic                       issue_now;
    logic                       issue;
    logic [CNT_W-1:0]           cnt_pix_i;
    logic [CNT_W-1:0]           cnt_pix_o;
    scaler_pkg::scale_step_t    out_pos;
    logic [`SCALER_PHASE_W-1:0] phase;

    // filter datapath
    scaler_pkg::pixel_t      tap_sr   [4];  // tap 3 is the newest pixel
    scaler_pkg::pixel_t      filt_tap [4];
    scaler_pkg::coe_t        coe      [4];
    logic [MUL_W-1:0]        mult_q   [4];
    logic signed [SUM_W-1:0] sum_q;
    scaler_pkg::pixel_t      clamp_pix;

    // strobe pipeline
    logic [1:0]      de_pipe;
    logic [1:0][1:0] sync_pipe;

    // ----------------------------------------
    // sync qualifiers
    // ----------------------------------------

    assign sync_in = {vs_i, hs_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_sr <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                sync_sr[k] <= {sync_sr[k][SYNC_HOLD-2:0], sync_in[k]};
            end
        end
    end

    // high now and for the previous four clocks
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            sync_q[k] = sync_in[k] & (&sync_sr[k]);
        end
    end

    assign sync_any  = |sync_q;
    assign accept    = de_i & ~sync_any;
    assign issue_now = ~sync_any & (cnt_pix_i > cnt_pix_o);

    // ----------------------------------------
    // coordinate counters
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_pix_i <= '0;
            cnt_pix_o <= '0;
            issue     <= 1'b0;
        end else begin
            issue <= issue_now;
            if (sync_any) begin
                cnt_pix_i <= '0;
                cnt_pix_o <= GRP_DELAY;          // filter group delay
            end else begin
                if (accept) begin
                    cnt_pix_i <= cnt_pix_i + ONE_PIX;
                end
                if (issue_now) begin
                    cnt_pix_o <= cnt_pix_o + CNT_W'(scale_step_i.raw);
                end
            end
        end
    end

    // low word of the output coordinate read as step fields
    assign out_pos.raw = cnt_pix_o[15:0];
    assign phase       = out_pos.f.frac[POS_FRAC_W-1 -: `SCALER_PHASE_W];

    // ----------------------------------------
    // tap window
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            tap_sr[3] <= pix_i;
            tap_sr[2] <= tap_sr[3];
            tap_sr[1] <= tap_sr[2];
            tap_sr[0] <= tap_sr[1];
        end
        if (issue_now) begin
            filt_tap <= tap_sr;      // frozen for the multiply
        end
    end

    // sampled on the pre-advance coordinate, ready with filt_tap
    scaler_coe_rom u_coe_rom (
        .clk     (clk),
        .phase_i (phase),
        .coe0_o  (coe[0]),
        .coe1_o  (coe[1]),
        .coe2_o  (coe[2]),
        .coe3_o  (coe[3])
    );

    // ----------------------------------------
    // multiply, sum, clamp
    // ----------------------------------------

    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            mult_q[k] <= coe[k] * filt_tap[k];
        end
        // outer lobes negative
        sum_q <= SUM_W'(mult_q[1]) + SUM_W'(mult_q[2])
               - SUM_W'(mult_q[0]) - SUM_W'(mult_q[3]) + ROUND_HALF;
    end

    always_comb begin
        if (sum_q[SUM_W-1]) begin
            clamp_pix = '0;                          // undershoot
        end else if (|sum_q[SUM_W-2:OVF_BIT]) begin
            clamp_pix = '1;                          // past full scale
        end else begin
            clamp_pix = sum_q[FRAC_W +: `SCALER_DATA_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            de_pipe   <= '0;
            sync_pipe <= '0;
            pix_o     <= '0;
            de_o      <= 1'b0;
            hs_o      <= 1'b0;
            vs_o      <= 1'b0;
        end else begin
            de_pipe      <= {de_pipe[0], issue};
            sync_pipe[0] <= sync_q;
            sync_pipe[1] <= sync_pipe[0];
            de_o         <= de_pipe[1];
            {vs_o, hs_o} <= sync_pipe[1];
            if (de_pipe[1]) begin
                pix_o <= clamp_pix;      // holds between strobes
            end
        end
    end

endmodule

// File: source/scaler_top.sv
// scaler subsystem top, one horizontal pass on a strobed pixel stream
// scale_step_i is a level, change it only while a sync is active
`timescale 1ns/1ps

module scaler_top (
    input  logic                    clk,
    input  logic                    rst,
    input  scaler_pkg::scale_step_t scale_step_i,   // 4.12, 4096 = 1.0
    // ----------------------------------------
    // input stream
    // ----------------------------------------
    input  scaler_pkg::pixel_t      pix_i,
    input  logic                    de_i,
    input  logic                    hs_i,
    input  logic                    vs_i,
    // ----------------------------------------
    // output stream, no back-pressure
    // ----------------------------------------
    output scaler_pkg::pixel_t      pix_o,
    output logic                    de_o,
    output logic                    hs_o,
    output logic                    vs_o
);

    // horizontal resampler
    // output strobes trail the qualified syncs by 3 clocks
    scaler_h u_scaler_h (
        .clk          (clk),
        .rst          (rst),
        .scale_step_i (scale_step_i),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

endmodule

// File: dv/tb_scaler.sv
// directed testbench for the horizontal scaler subsystem
// drives strobed lines on the falling edge, collects de_o pixels in a queue
// each test task checks its own results, a summary line closes the run
`timescale 1ns/1ps

`include "scaler_config.svh"

module tb_scaler;

    localparam int LINE_LEN  = 256;
    localparam int UNIT      = `SCALER_PIX_STEP;
    localparam int QUIET_CLK = 16;      // de_o low this long ends a line
    localparam int WAIT_MAX  = 4000;

    logic                    clk = 1'b0;
    logic                    rst;
    scaler_pkg::scale_step_t scale_step_i;
    scaler_pkg::pixel_t      pix_i;
    logic                    de_i;
    logic                    hs_i;
    logic                    vs_i;
    scaler_pkg::pixel_t      pix_o;
    logic                    de_o;
    logic                    hs_o;
    logic                    vs_o;

    scaler_pkg::pixel_t line_buf [LINE_LEN];
    scaler_pkg::pixel_t out_q [$];

    int err_cnt   = 0;
    int check_cnt = 0;
    int test_cnt  = 0;

    scaler_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .scale_step_i (scale_step_i),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    always #20 clk = ~clk;      // 40 ns period

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (de_o) begin
            out_q.push_back(pix_o);
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_pixel(string name, scaler_pkg::pixel_t got, scaler_pkg::pixel_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        check_cnt++;
        if (got != exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt++;
        $display("test %-14s %0d errors", name, err_cnt - errs_before);
    endtask

    // ----------------------------------------
    // reference rules
    // ----------------------------------------

    // output coordinates 3u, 3u+step, ... that fall before the line end
    function automatic int expected_count(int n, int step);
        int pos;
        int cnt;
        pos = 3 * UNIT;
        cnt = 0;
        while (pos < n * UNIT) begin
            cnt++;
            pos += step;
        end
        return cnt;
    endfunction

    // pixels accepted when output k issues, window is the last four
    function automatic int window_end(int k, int n, int step);
        int m;
        m = (3 * UNIT + k * step) / UNIT + 1;
        if (m > n) begin
            m = n;      // taps freeze once the line has ended
        end
        return m;
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    task automatic wait_quiet(string what);
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CLK && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
            if (de_o) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < QUIET_CLK) begin
            $display("ERROR %0t: output stream of %s never went idle", $time, what);
            err_cnt++;
        end
    endtask

    // hs for 8 clocks, line_buf with de high, then idle
    task automatic drive_line(int step, int glitch_at, string what);
        int i;
        out_q.delete();
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            hs_i = 1'b1;
            de_i = 1'b0;
            if (i == 5) begin
                scale_step_i.raw = step[15:0];     // sync already qualified here
            end
        end
        for (i = 0; i < LINE_LEN; i++) begin
            @(negedge clk);
            hs_i  = (glitch_at >= 0) && (i >= glitch_at) && (i < glitch_at + 3);
            de_i  = 1'b1;
            pix_i = line_buf[i];
        end
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            hs_i  = 1'b0;
            de_i  = 1'b0;
            pix_i = '0;
        end
        wait_quiet(what);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset();
        int errs;
        int i;
        errs = err_cnt;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_bit("de_o", de_o, 1'b0);
            check_bit("hs_o", hs_o, 1'b0);
            check_bit("vs_o", vs_o, 1'b0);
            check_pixel("pix_o", pix_o, '0);
        end
        report_test("reset", errs);
    endtask

    // every row nets 512, so a flat line comes out unchanged
    task automatic test_flat(int step);
        int errs;
        int i;
        scaler_pkg::pixel_t v;
        errs = err_cnt;
        v    = scaler_pkg::pixel_t'($urandom);
        for (i = 0; i < LINE_LEN; i++) begin
            line_buf[i] = v;
        end
        drive_line(step, -1, "flat line");
        check_bit("de_o seen", out_q.size() > 0, 1'b1);
        foreach (out_q[k]) begin
            check_pixel("pix_o", out_q[k], v);
        end
        report_test($sformatf("flat %0d", step), errs);
    endtask

    task automatic test_count(int step);
        int errs;
        int i;
        errs = err_cnt;
        for (i = 0; i < LINE_LEN; i++) begin
            line_buf[i] = scaler_pkg::pixel_t'($urandom);
        end
        drive_line(step, -1, "count line");
        check_count("de_o count", out_q.size(), expected_count(LINE_LEN, step));
        report_test($sformatf("count %0d", step), errs);
    endtask

    // phase stays 0 at 1.0, so the output is the delayed ramp
    task automatic test_identity();
        int errs;
        int i;
        int start;
        errs  = err_cnt;
        start = -1;
        for (i = 0; i < LINE_LEN; i++) begin
            line_buf[i] = scaler_pkg::pixel_t'(i);
        end
        drive_line(UNIT, -1, "ramp line");
        if (out_q.size() > 0) begin
            for (i = 0; i < LINE_LEN && start < 0; i++) begin
                if (line_buf[i] == out_q[0]) begin
                    start = i;
                end
            end
        end
        if (start < 0) begin
            $display("ERROR %0t: no output matches any pixel of the input ramp", $time);
            err_cnt++;
        end else begin
            for (i = 0; i < out_q.size() && start + i < LINE_LEN; i++) begin
                check_pixel("pix_o", out_q[i], line_buf[start + i]);
            end
        end
        report_test("identity", errs);
    endtask

    // runs of 4 make windows where the lobes push past a rail
    task automatic test_clamp();
        int errs;
        int i;
        int m;
        int seen;
        scaler_pkg::pixel_t w0;
        scaler_pkg::pixel_t w1;
        scaler_pkg::pixel_t w2;
        scaler_pkg::pixel_t w3;
        errs = err_cnt;
        seen = 0;
        for (i = 0; i < LINE_LEN; i++) begin
            line_buf[i] = ((i / 4) % 2 == 1) ? 8'hff : 8'h00;
        end
        drive_line(6144, -1, "edge line");
        check_count("de_o count", out_q.size(), expected_count(LINE_LEN, 6144));
        for (i = 0; i < out_q.size(); i++) begin
            m  = window_end(i, LINE_LEN, 6144);
            w0 = line_buf[m - 4];
            w1 = line_buf[m - 3];
            w2 = line_buf[m - 2];
            w3 = line_buf[m - 1];
            // three equal rails, the odd outer tap only overshoots outward
            if (w1 == w2 && (w0 == w1 || w3 == w1)) begin
                check_pixel("pix_o", out_q[i], w1);
                seen++;
            end
        end
        check_bit("rail windows seen", seen > 0, 1'b1);
        report_test("clamp", errs);
    endtask

    task automatic test_glitch();
        int errs;
        int i;
        errs = err_cnt;
        for (i = 0; i < LINE_LEN; i++) begin
            line_buf[i] = scaler_pkg::pixel_t'($urandom);
        end
        drive_line(6144, 100, "glitch line");     // 3 clock hs mid-line
        check_count("de_o count", out_q.size(), expected_count(LINE_LEN, 6144));
        report_test("hs glitch", errs);
    endtask

    // long sync, output starts 7 clocks later and is 4 clocks shorter
    task automatic test_sync(bit use_vs, int len);
        int errs;
        int i;
        int first_hi;
        int hi_cnt;
        logic strobe;
        logic other;
        errs     = err_cnt;
        first_hi = -1;
        hi_cnt   = 0;
        for (i = 0; i < len + 16; i++) begin
            @(negedge clk);
            strobe = use_vs ? vs_o : hs_o;
            other  = use_vs ? hs_o : vs_o;
            if (strobe) begin
                if (first_hi < 0) begin
                    first_hi = i;
                end
                hi_cnt++;
            end
            check_bit(use_vs ? "hs_o" : "vs_o", other, 1'b0);
            check_bit("de_o", de_o, 1'b0);
            if (use_vs) begin
                vs_i = (i < len);
            end else begin
                hs_i = (i < len);
            end
        end
        check_count(use_vs ? "vs_o delay" : "hs_o delay", first_hi, 7);
        check_count(use_vs ? "vs_o width" : "hs_o width", hi_cnt, len - 4);
        report_test(use_vs ? "vs pulse" : "hs pulse", errs);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        rst              = 1'b1;
        scale_step_i.raw = 16'(UNIT);
        pix_i            = '0;
        de_i             = 1'b0;
        hs_i             = 1'b0;
        vs_i             = 1'b0;
        void'($urandom(32'h50c1_b330));

        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_flat(4096);
        test_flat(6144);
        test_flat(8192);
        test_count(4096);
        test_count(6144);
        test_count(8192);
        test_identity();
        test_clamp();
        test_glitch();
        test_sync(1'b0, 20);
        test_sync(1'b1, 20);

        $display("tests %0d  checks %0d  errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
source/scaler_pkg.sv
source/scaler_coe_rom.sv
source/scaler_h.sv
source/scaler_top.sv
dv/tb_scaler.sv

// File: Makefile
# Verilator build and run of the horizontal scaler testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_scaler -f flist.f -o tb_scaler
	./obj_dir/tb_scaler | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
